// ==== hw/pipe_pkg.sv ====
// Shared widths, opcode encoding and forwarding selects, imported by every RTL block
package pipe_pkg;

    typedef logic [15:0] word_t;       // Data word and register value
    typedef logic [15:0] instr_t;      // [15:12] op, [11:10] rd, [9:8] rs, [7:0] imm
    typedef logic [7:0]  pc_t;         // Word address into instruction memory
    typedef logic [1:0]  reg_idx_t;
    typedef logic [7:0]  seq_t;        // Wraps
    typedef logic [15:0] cycle_t;      // Counted from end of reset
    typedef logic [3:0]  stall_cnt_t;  // Saturates

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADDI = 4'h1,
        OP_ADD  = 4'h2,
        OP_LD   = 4'h3,
        OP_ST   = 4'h4,
        OP_BNZ  = 4'h5
    } opcode_e;

    // Execute operand source
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    localparam int     NUM_REGS  = 4;
    localparam instr_t NOP_INSTR = 16'h0000;  // Bubble in IF/ID

endpackage

// ==== hw/hazard_unit.sv ====
// Combinational hazard logic: load-use stall, branch flush and execute forwarding selects
`timescale 1ns/1ps

module hazard_unit (
    input  pipe_pkg::opcode_e  id_op,
    input  pipe_pkg::reg_idx_t id_rs,
    input  pipe_pkg::reg_idx_t id_rd,
    input  pipe_pkg::reg_idx_t ex_rd,
    input  logic               ex_is_load,
    input  logic               ex_br_taken,
    input  pipe_pkg::reg_idx_t mem_rd,
    input  logic               mem_we,
    input  pipe_pkg::reg_idx_t wb_rd,
    input  logic               wb_we,
    input  pipe_pkg::reg_idx_t ex_rs,
    input  pipe_pkg::reg_idx_t ex_rd_src,
    output logic               stall,
    output logic               flush,
    output pipe_pkg::fwd_sel_e fwd_a,
    output pipe_pkg::fwd_sel_e fwd_b
);
    import pipe_pkg::*;

    logic reads_rs;
    logic reads_rd;
    logic load_use;

    // Memory stage is younger, so it wins over write-back
    function automatic fwd_sel_e fwd_src(input reg_idx_t src);
        if (mem_we && mem_rd == src)
            return FWD_MEM;
        if (wb_we && wb_rd == src)
            return FWD_WB;
        return FWD_RF;
    endfunction

    // Source registers actually read by the decode opcode
    always_comb begin
        reads_rs = 1'b0;
        reads_rd = 1'b0;
        case (id_op)
            OP_ADDI, OP_LD, OP_BNZ: reads_rs = 1'b1;
            OP_ADD, OP_ST: begin
                reads_rs = 1'b1;
                reads_rd = 1'b1;   // ADD accumulates into rd, ST stores rd
            end
            default: ;
        endcase
    end

    assign load_use = ex_is_load &&
                      ((reads_rs && ex_rd == id_rs) || (reads_rd && ex_rd == id_rd));

    assign flush = ex_br_taken;
    assign stall = load_use;  // A load in execute is never a branch

    always_comb begin
        fwd_a = fwd_src(ex_rs);
        fwd_b = fwd_src(ex_rd_src);
    end

endmodule

// ==== hw/pipe_core.sv ====
// Five-stage pipeline datapath with register file and data memory, steered by the hazard unit
`timescale 1ns/1ps

module pipe_core #(
    parameter int DMEM_WORDS = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  pipe_pkg::instr_t   fetch_instr,
    input  logic               stall,
    input  logic               flush,
    input  pipe_pkg::fwd_sel_e fwd_a,
    input  pipe_pkg::fwd_sel_e fwd_b,
    output pipe_pkg::pc_t      fetch_pc,
    output pipe_pkg::opcode_e  id_op,
    output pipe_pkg::reg_idx_t id_rs,
    output pipe_pkg::reg_idx_t id_rd,
    output pipe_pkg::reg_idx_t ex_rd,
    output logic               ex_is_load,
    output logic               ex_br_taken,
    output pipe_pkg::reg_idx_t ex_rs,
    output pipe_pkg::reg_idx_t ex_rd_src,
    output pipe_pkg::reg_idx_t mem_rd,
    output logic               mem_we,
    output pipe_pkg::reg_idx_t wb_rd,
    output logic               wb_we,
    output pipe_pkg::word_t    wb_data
);
    import pipe_pkg::*;

    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    instr_t   ifid_instr;
    pc_t      ifid_pc;
    opcode_e  idex_op;
    reg_idx_t idex_rd;
    reg_idx_t idex_rs;
    logic [7:0] idex_imm;
    pc_t      idex_pc;
    word_t    idex_a;           // rs value
    word_t    idex_b;           // rd value
    opcode_e  exmem_op;
    reg_idx_t exmem_rd;
    logic     exmem_we;
    word_t    exmem_alu;
    word_t    exmem_st;
    reg_idx_t memwb_rd;
    logic     memwb_we;
    word_t    memwb_data;

    word_t regs [NUM_REGS];
    word_t dmem [DMEM_WORDS];

    word_t id_a;
    word_t id_b;
    word_t ex_a;
    word_t ex_b;
    word_t ex_alu;
    logic  ex_we;
    pc_t   branch_target;
    logic [DMEM_AW-1:0] mem_addr;
    word_t mem_result;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////
    assign id_op = opcode_e'(ifid_instr[15:12]);
    assign id_rd = ifid_instr[11:10];
    assign id_rs = ifid_instr[9:8];

    // Read-through so a write-back in this cycle is seen here
    assign id_a = (wb_we && wb_rd == id_rs) ? wb_data : regs[id_rs];
    assign id_b = (wb_we && wb_rd == id_rd) ? wb_data : regs[id_rd];

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (fwd_a)
            FWD_MEM: ex_a = mem_result;
            FWD_WB:  ex_a = wb_data;
            default: ex_a = idex_a;
        endcase
        case (fwd_b)
            FWD_MEM: ex_b = mem_result;
            FWD_WB:  ex_b = wb_data;
            default: ex_b = idex_b;
        endcase
    end

    always_comb begin
        ex_alu = ex_a + word_t'(idex_imm);  // ADDI and LD/ST address
        ex_we  = 1'b0;
        case (idex_op)
            OP_ADDI, OP_LD: ex_we = 1'b1;
            OP_ADD: begin
                ex_alu = ex_b + ex_a;
                ex_we  = 1'b1;
            end
            default: ;
        endcase
    end

    assign ex_br_taken   = (idex_op == OP_BNZ) && (ex_a != '0);
    assign branch_target = idex_pc + pc_t'(idex_imm);  // 8-bit wrap acts as sign extension
    assign ex_is_load    = (idex_op == OP_LD);
    assign ex_rd         = idex_rd;
    assign ex_rs         = idex_rs;
    assign ex_rd_src     = idex_rd;

    ////////////////////////////////////////////////////////////
    // Memory and write-back
    ////////////////////////////////////////////////////////////
    assign mem_addr   = exmem_alu[DMEM_AW-1:0];
    assign mem_result = (exmem_op == OP_LD) ? dmem[mem_addr] : exmem_alu;
    assign mem_rd     = exmem_rd;
    assign mem_we     = exmem_we;

    assign wb_rd   = memwb_rd;
    assign wb_we   = memwb_we;
    assign wb_data = memwb_data;

    // Control state and bubbles
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc   <= '0;
            ifid_instr <= NOP_INSTR;
            idex_op    <= OP_NOP;
            exmem_op   <= OP_NOP;
            exmem_we   <= 1'b0;
            memwb_we   <= 1'b0;
        end else begin
            if (flush)
                fetch_pc <= branch_target;
            else if (!stall)
                fetch_pc <= fetch_pc + 1'b1;
            if (flush)
                ifid_instr <= NOP_INSTR;
            else if (!stall)
                ifid_instr <= fetch_instr;
            idex_op  <= (stall || flush) ? OP_NOP : id_op;
            exmem_op <= idex_op;
            exmem_we <= ex_we;
            memwb_we <= exmem_we;
        end
    end

    // Payload follows the stage ops
    always_ff @(posedge clk) begin
        if (!stall)
            ifid_pc <= fetch_pc;
        idex_rd    <= id_rd;
        idex_rs    <= id_rs;
        idex_imm   <= ifid_instr[7:0];
        idex_pc    <= ifid_pc;
        idex_a     <= id_a;
        idex_b     <= id_b;
        exmem_rd   <= idex_rd;
        exmem_alu  <= ex_alu;
        exmem_st   <= ex_b;             // Store data is rd
        memwb_rd   <= exmem_rd;
        memwb_data <= mem_result;
        if (exmem_op == OP_ST)
            dmem[mem_addr] <= exmem_st;
    end

    // Architectural registers start at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (memwb_we) begin
            regs[memwb_rd] <= memwb_data;
        end
    end

endmodule

// ==== hw/pipe_tracker.sv ====
// Shadow pipeline that follows each fetched slot to write-back and emits a numeric retire record
`timescale 1ns/1ps

module pipe_tracker (
    input  logic                 clk,
    input  logic                 rst,
    input  pipe_pkg::pc_t        fetch_pc,
    input  logic                 stall,
    input  logic                 flush,
    output logic                 retire_valid,
    output pipe_pkg::seq_t       retire_seq,
    output pipe_pkg::pc_t        retire_pc,
    output pipe_pkg::cycle_t     retire_fetch_cycle,
    output pipe_pkg::cycle_t     retire_cycle,
    output pipe_pkg::stall_cnt_t retire_stalls
);
    import pipe_pkg::*;

    // Registered slots, fetch itself is the live PC plus next_seq
    localparam int SLOT_ID  = 0;
    localparam int SLOT_EX  = 1;
    localparam int SLOT_MEM = 2;
    localparam int SLOT_WB  = 3;

    cycle_t cyc;
    seq_t   next_seq;           // Number for the slot now in fetch

    logic [SLOT_WB:SLOT_ID] slot_vld;
    seq_t       slot_seq    [SLOT_WB+1];
    pc_t        slot_pc     [SLOT_WB+1];
    cycle_t     slot_fcyc   [SLOT_WB+1];
    stall_cnt_t slot_stalls [SLOT_WB+1];

    ////////////////////////////////////////////////////////////
    // Valid bits and counters, same rules as the core
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cyc      <= '0;
            next_seq <= '0;
            slot_vld <= '0;
        end else begin
            cyc <= cyc + 1'b1;
            if (!stall)
                next_seq <= next_seq + 1'b1;   // Flushed fetch slot still uses its number

            if (flush)
                slot_vld[SLOT_ID] <= 1'b0;
            else if (!stall)
                slot_vld[SLOT_ID] <= 1'b1;
            slot_vld[SLOT_EX]  <= slot_vld[SLOT_ID] && !stall && !flush;
            slot_vld[SLOT_MEM] <= slot_vld[SLOT_EX];
            slot_vld[SLOT_WB]  <= slot_vld[SLOT_MEM];
        end
    end

    ////////////////////////////////////////////////////////////
    // Slot payload
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!stall) begin
            slot_seq[SLOT_ID]    <= next_seq;
            slot_pc[SLOT_ID]     <= fetch_pc;
            slot_fcyc[SLOT_ID]   <= cyc;   // Stamped on the cycle it leaves fetch
            slot_stalls[SLOT_ID] <= '0;
        end else if (slot_stalls[SLOT_ID] != '1) begin
            slot_stalls[SLOT_ID] <= slot_stalls[SLOT_ID] + 1'b1;
        end

        for (int i = SLOT_EX; i <= SLOT_WB; i++) begin
            slot_seq[i]    <= slot_seq[i-1];
            slot_pc[i]     <= slot_pc[i-1];
            slot_fcyc[i]   <= slot_fcyc[i-1];
            slot_stalls[i] <= slot_stalls[i-1];
        end
    end

    // Record of the slot in write-back
    assign retire_valid       = slot_vld[SLOT_WB];
    assign retire_seq         = slot_seq[SLOT_WB];
    assign retire_pc          = slot_pc[SLOT_WB];
    assign retire_fetch_cycle = slot_fcyc[SLOT_WB];
    assign retire_cycle       = cyc;
    assign retire_stalls      = slot_stalls[SLOT_WB];

endmodule

// ==== hw/traced_cpu_top.sv ====
// Top level of the traced processor: core, hazard unit and retire tracker wired together
`timescale 1ns/1ps

module traced_cpu_top #(
    parameter int DMEM_WORDS = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  pipe_pkg::instr_t     fetch_instr,
    output pipe_pkg::pc_t        fetch_pc,
    output logic                 wb_we,
    output pipe_pkg::reg_idx_t   wb_rd,
    output pipe_pkg::word_t      wb_data,
    output logic                 retire_valid,
    output pipe_pkg::seq_t       retire_seq,
    output pipe_pkg::pc_t        retire_pc,
    output pipe_pkg::cycle_t     retire_fetch_cycle,
    output pipe_pkg::cycle_t     retire_cycle,
    output pipe_pkg::stall_cnt_t retire_stalls
);
    import pipe_pkg::*;

    opcode_e  id_op;
    reg_idx_t id_rs;
    reg_idx_t id_rd;
    reg_idx_t ex_rd;
    reg_idx_t ex_rs;
    reg_idx_t ex_rd_src;
    reg_idx_t mem_rd;
    logic     ex_is_load;
    logic     ex_br_taken;
    logic     mem_we;
    logic     stall;
    logic     flush;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    pipe_core #(
        .DMEM_WORDS(DMEM_WORDS)
    ) i_pipe_core (
        .clk(clk), .rst(rst), .fetch_instr(fetch_instr),
        .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .fetch_pc(fetch_pc), .id_op(id_op), .id_rs(id_rs), .id_rd(id_rd),
        .ex_rd(ex_rd), .ex_is_load(ex_is_load), .ex_br_taken(ex_br_taken),
        .ex_rs(ex_rs), .ex_rd_src(ex_rd_src), .mem_rd(mem_rd), .mem_we(mem_we),
        .wb_rd(wb_rd), .wb_we(wb_we), .wb_data(wb_data)
    );

    hazard_unit i_hazard_unit (
        .id_op(id_op), .id_rs(id_rs), .id_rd(id_rd),
        .ex_rd(ex_rd), .ex_is_load(ex_is_load), .ex_br_taken(ex_br_taken),
        .mem_rd(mem_rd), .mem_we(mem_we), .wb_rd(wb_rd), .wb_we(wb_we),
        .ex_rs(ex_rs), .ex_rd_src(ex_rd_src),
        .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    pipe_tracker i_pipe_tracker (
        .clk(clk), .rst(rst), .fetch_pc(fetch_pc), .stall(stall), .flush(flush),
        .retire_valid(retire_valid), .retire_seq(retire_seq), .retire_pc(retire_pc),
        .retire_fetch_cycle(retire_fetch_cycle), .retire_cycle(retire_cycle),
        .retire_stalls(retire_stalls)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
// Testbench clock and reset source, a 40 ns clock with reset held for the first four cycles
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RST_CYCLES     = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Released on a falling edge, like every other testbench drive
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== sim/traced_cpu_assertions.sv ====
// Concurrent checks on tracker control inputs and retire records, bound into pipe_tracker
`timescale 1ns/1ps

module traced_cpu_assertions (
    input logic                 clk,
    input logic                 rst,
    input logic                 stall,
    input logic                 flush,
    input logic                 retire_valid,
    input pipe_pkg::cycle_t     retire_fetch_cycle,
    input pipe_pkg::cycle_t     retire_cycle,
    input pipe_pkg::stall_cnt_t retire_stalls
);
    import pipe_pkg::*;

    localparam cycle_t FILL_CYCLES = 16'd4;  // Fetch to write-back with no stall

    // Nothing leaves write-back before the pipeline has filled
    no_early_retire: assert property (
        @(posedge clk) disable iff (rst) (retire_cycle < FILL_CYCLES) |-> !retire_valid
    ) else $error("retire_valid high before the pipeline filled");

    stall_flush_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(stall && flush)
    ) else $error("stall and flush high in the same cycle");

    // Minimum latency means the slot never sat in decode
    no_stall_no_count: assert property (
        @(posedge clk) disable iff (rst)
        (retire_valid && (retire_cycle - retire_fetch_cycle) == FILL_CYCLES)
        |-> (retire_stalls == '0)
    ) else $error("retire_stalls nonzero on a retire with minimum latency");

endmodule

bind pipe_tracker traced_cpu_assertions i_traced_cpu_assertions (
    .clk(clk), .rst(rst), .stall(stall), .flush(flush), .retire_valid(retire_valid),
    .retire_fetch_cycle(retire_fetch_cycle), .retire_cycle(retire_cycle),
    .retire_stalls(retire_stalls)
);

// ==== sim/tb_traced_cpu.sv ====
// Testbench for the traced processor, serves fetches from the stim file and checks retire records
`timescale 1ns/1ps

module tb_traced_cpu;
    import pipe_pkg::*;

    localparam int STIM_WORDS = 512;
    localparam int REC_FIELDS = 6;   // seq pc stalls wb_we wb_rd wb_data

    logic       clk;
    logic       rst;
    instr_t     fetch_instr;
    pc_t        fetch_pc;
    logic       wb_we;
    reg_idx_t   wb_rd;
    word_t      wb_data;
    logic       retire_valid;
    seq_t       retire_seq;
    pc_t        retire_pc;
    cycle_t     retire_fetch_cycle;
    cycle_t     retire_cycle;
    stall_cnt_t retire_stalls;

    logic [15:0] stim [STIM_WORDS];
    int   prog_len;
    int   rec_count;
    int   rec_base;                  // Index of the first record word
    int   rec_idx;
    int   cycle_limit;
    int   cycles;
    logic seen_retire;
    seq_t last_seq;

    tb_clock_gen i_tb_clock_gen (.clk(clk), .rst(rst));

    traced_cpu_top #(
        .DMEM_WORDS(16)
    ) i_traced_cpu_top (
        .clk(clk), .rst(rst), .fetch_instr(fetch_instr), .fetch_pc(fetch_pc),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
        .retire_valid(retire_valid), .retire_seq(retire_seq), .retire_pc(retire_pc),
        .retire_fetch_cycle(retire_fetch_cycle), .retire_cycle(retire_cycle),
        .retire_stalls(retire_stalls)
    );

    ////////////////////////////////////////////////////////////
    // Failure exit and compare tasks
    ////////////////////////////////////////////////////////////
    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_seq(input string name, input seq_t actual, input seq_t expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h (record %0d)",
                     name, actual, expected, rec_idx);
            abort_run();
        end
    endtask

    task automatic check_pc(input string name, input pc_t actual, input pc_t expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h (record %0d)",
                     name, actual, expected, rec_idx);
            abort_run();
        end
    endtask

    task automatic check_stalls(input string name, input stall_cnt_t actual,
                                input stall_cnt_t expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h (record %0d)",
                     name, actual, expected, rec_idx);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h (record %0d)",
                     name, actual, expected, rec_idx);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t actual,
                             input reg_idx_t expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h (record %0d)",
                     name, actual, expected, rec_idx);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h (record %0d)",
                     name, actual, expected, rec_idx);
            abort_run();
        end
    endtask

    // Four cycles through the pipe plus one per stall cycle in decode
    task automatic check_latency(input cycle_t fetch_cyc, input cycle_t retire_cyc,
                                 input stall_cnt_t stalls);
        cycle_t expected;
        expected = fetch_cyc + cycle_t'(4) + cycle_t'(stalls);
        if (fetch_cyc >= retire_cyc) begin
            $display("Retire cycle is not after the fetch cycle in record %0d", rec_idx);
            abort_run();
        end
        if (retire_cyc !== expected) begin
            $display("Error: retire_cycle is 0x%h, expected 0x%h (record %0d)",
                     retire_cyc, expected, rec_idx);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stim access
    ////////////////////////////////////////////////////////////
    function automatic instr_t imem_word(input pc_t pc);
        if (int'(pc) < prog_len)
            return instr_t'(stim[1 + int'(pc)]);
        return NOP_INSTR;   // Past the end of the program
    endfunction

    task automatic check_record();
        int         base;
        logic       exp_we;
        stall_cnt_t exp_stalls;
        base       = rec_base + rec_idx * REC_FIELDS;
        exp_we     = stim[base + 3][0];
        exp_stalls = stall_cnt_t'(stim[base + 2]);
        if (seen_retire && retire_seq <= last_seq) begin
            $display("Retire order broken, seq 0x%h came after 0x%h", retire_seq, last_seq);
            abort_run();
        end
        check_seq("retire_seq", retire_seq, seq_t'(stim[base]));
        check_pc("retire_pc", retire_pc, pc_t'(stim[base + 1]));
        check_stalls("retire_stalls", retire_stalls, exp_stalls);
        check_flag("wb_we", wb_we, exp_we);
        if (exp_we) begin
            check_reg("wb_rd", wb_rd, reg_idx_t'(stim[base + 4]));
            check_word("wb_data", wb_data, word_t'(stim[base + 5]));
        end
        check_latency(retire_fetch_cycle, retire_cycle, exp_stalls);
        seen_retire = 1'b1;
        last_seq    = retire_seq;
        rec_idx     = rec_idx + 1;
    endtask

    ////////////////////////////////////////////////////////////
    // Fetch service, timeout and main sequence
    ////////////////////////////////////////////////////////////
    always @(negedge clk)
        fetch_instr <= imem_word(fetch_pc);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d retire records seen",
                     cycles, rec_idx, rec_count);
            abort_run();
        end
    end

    initial begin
        fetch_instr = NOP_INSTR;
        rec_idx     = 0;
        cycles      = 0;
        seen_retire = 1'b0;
        last_seq    = '0;
        $readmemh("sim/traced_cpu_stim.txt", stim);
        prog_len    = int'(stim[0]);
        rec_count   = int'(stim[prog_len + 1]);
        rec_base    = prog_len + 2;
        cycle_limit = rec_count * 8 + 20;
        if (rec_count == 0 || rec_base + rec_count * REC_FIELDS > STIM_WORDS) begin
            $display("Stim file holds no records or overruns the stim buffer");
            abort_run();
        end

        // Outputs are stable at the falling edge
        while (rec_idx < rec_count) begin
            @(negedge clk);
            if (!rst && retire_valid)
                check_record();
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== compile.f ====
hw/pipe_pkg.sv
hw/hazard_unit.sv
hw/pipe_core.sv
hw/pipe_tracker.sv
hw/traced_cpu_top.sv
sim/tb_clock_gen.sv
sim/traced_cpu_assertions.sv
sim/tb_traced_cpu.sv

// ==== Makefile ====
# Verilator build and run of the traced processor testbench

SIM := obj_dir/Vtb_traced_cpu

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module tb_traced_cpu -f compile.f
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== sim/traced_cpu_stim.txt ====
// Program word count, program words in PC order, record count, then one retire record per line
// Record columns: seq pc stalls wb_we wb_rd wb_data, wb_rd and wb_data count only with wb_we 1
0010
1405 1903 2900 2600
1C04 4703 3B03 2A00
5203 1F40 1F40 1F01
5004 1710 0000 3302
000E
00 00 0 1 1 0005
01 01 0 1 2 0008
02 02 0 1 2 000D
03 03 0 1 1 0012
04 04 0 1 3 0004
05 05 0 0 0 0000  // ST r1 to r3 plus 3
06 06 0 1 2 0012  // LD from the same address
07 07 1 1 2 0024  // Load-use stall
08 08 0 0 0 0000  // Taken BNZ, seq 09 and 0A flushed
0B 0B 0 1 3 0005
0C 0C 0 0 0 0000  // Untaken BNZ
0D 0D 0 1 1 0015
0E 0E 0 0 0 0000  // NOP
0F 0F 0 1 0 0012
